/* tb.f */
+incdir+.
keccak_pkg.sv
keccak_block_pad.sv
keccak_round.sv
keccak_round_pipe.sv
keccak_target_check.sv
keccak_miner.sv
tb_keccak_miner.sv

/* Bender.yml */
package:
  name: keccak_miner

sources:
  - keccak_pkg.sv
  - keccak_block_pad.sv
  - keccak_round.sv
  - keccak_round_pipe.sv
  - keccak_target_check.sv
  - keccak_miner.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_keccak_miner.sv

/* tb_keccak_model.svh */
`ifndef TB_KECCAK_MODEL_SVH
`define TB_KECCAK_MODEL_SVH

function automatic lane_t model_rotl(lane_t v, int n);
  return (v << n) | (v >> (64 - n));
endfunction

////////////////////////////////////////
// keccak-256 of header + nonce, one block
////////////////////////////////////////
// constants are derived here from the lfsr and the rho walk
function automatic digest_t keccak256_ref(header_t header, nonce_t nonce);
  logic [7:0]   msg [136];
  logic [639:0] stream;
  lane_t        a [25];
  lane_t        b [25];
  lane_t        c [5];
  lane_t        d [5];
  lane_t        rc_lane;
  int           rho [25];
  int           x;
  int           y;
  int           tmp;
  logic [7:0]   lfsr;
  digest_t      dig;

  stream = {header, nonce};
  for (int i = 0; i < 136; i++)
    msg[i] = (i < 80) ? stream[639 - 8*i -: 8] : 8'h00;
  msg[80]  = msg[80] | 8'h01;
  msg[135] = msg[135] | 8'h80;

  for (int k = 0; k < 25; k++)
    a[k] = '0;
  for (int k = 0; k < 17; k++)
    for (int j = 0; j < 8; j++)
      a[k][8*j +: 8] = msg[8*k + j];

  rho[0] = 0;
  x = 1;
  y = 0;
  for (int t = 0; t < 24; t++)
  begin
    rho[x + 5*y] = ((t + 1) * (t + 2) / 2) % 64;
    tmp = x;
    x = y;
    y = (2*tmp + 3*y) % 5;
  end

  lfsr = 8'h01;
  for (int r = 0; r < 24; r++)
  begin
    for (int i = 0; i < 5; i++)
      c[i] = a[i] ^ a[i+5] ^ a[i+10] ^ a[i+15] ^ a[i+20];
    for (int i = 0; i < 5; i++)
      d[i] = c[(i+4) % 5] ^ model_rotl(c[(i+1) % 5], 1);
    for (int yy = 0; yy < 5; yy++)
      for (int xx = 0; xx < 5; xx++)
        b[yy + 5*((2*xx + 3*yy) % 5)] = model_rotl(a[xx + 5*yy] ^ d[xx], rho[xx + 5*yy]);
    for (int yy = 0; yy < 5; yy++)
      for (int xx = 0; xx < 5; xx++)
        a[xx + 5*yy] = b[xx + 5*yy] ^ (~b[(xx+1) % 5 + 5*yy] & b[(xx+2) % 5 + 5*yy]);

    rc_lane = '0;
    for (int j = 0; j < 7; j++)
    begin
      rc_lane[(1 << j) - 1] = lfsr[0];
      lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
    end
    a[0] = a[0] ^ rc_lane;
  end

  for (int k = 0; k < 4; k++)
    for (int j = 0; j < 8; j++)
      dig[255 - 8*(8*k + j) -: 8] = a[k][8*j +: 8];
  return dig;
endfunction

// zero prefix plus low word at most the target
function automatic bit keccak_match_ref(digest_t dig, target_t target, int zero_bits);
  return ((dig >> (256 - zero_bits)) == '0) && (dig[31:0] <= target);
endfunction

`endif

/* tb_keccak_miner.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_keccak_miner
  import keccak_pkg::*;
();

  `include "tb_keccak_model.svh"

  localparam int ZERO_BITS = 8;     // low enough for real matches
  localparam int LATENCY   = 48;    // register stages, sampling edge included
  localparam int NUM_ROWS  = 4;
  localparam int TIMEOUT   = LATENCY + 100;

  typedef struct packed {
    logic [31:0] header_seed;   // 0 gives an all-zero header
    nonce_t      start_nonce;
    int          count;
    target_t     target;
    int          gap_pct;       // chance of an idle cycle, percent
    int          exp_matches;   // -1 where not fixed
  } row_t;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    in_valid;
  header_t header;
  nonce_t  nonce;
  target_t target;
  digest_t digest;
  logic    match;
  logic    out_valid;

  row_t    rows [NUM_ROWS];
  row_t    reset_row;
  digest_t exp_digest_q [$];
  bit      exp_match_q [$];
  int      exp_cycle_q [$];
  int      cycle_cnt = 0;
  int      match_seen = 0;

  keccak_miner #(
    .ZERO_BITS (ZERO_BITS)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .header    (header),
    .nonce     (nonce),
    .target    (target),
    .digest    (digest),
    .match     (match),
    .out_valid (out_valid)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  ////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////
  always @(negedge clk)
  begin
    if (rst_n === 1'b1)
    begin
      if (out_valid === 1'b1)
      begin
        if (exp_digest_q.size() == 0)
          abort_run("out_valid pulsed with no accepted input pending");
        else
        begin
          check_value("digest", digest, exp_digest_q.pop_front());
          check_value("match", match, exp_match_q.pop_front());
          check_value("latency", cycle_cnt, exp_cycle_q.pop_front());
          match_seen += match;
        end
      end
      else
        check_value("match", match, 1'b0);  // idle cycles keep match low
    end
  end

  // one row: header, nonce run, optional idle gaps
  task automatic drive_row(input row_t row);
    header_t hdr;
    nonce_t  n;
    int      sent;
    digest_t dig;
    bit      m;
    hdr = '0;
    if (row.header_seed != 0)
    begin
      for (int w = 0; w < HEADER_W/32; w++)
        hdr[32*w +: 32] = $urandom ^ row.header_seed;
    end
    n = row.start_nonce;
    sent = 0;
    while (sent < row.count)
    begin
      @(negedge clk);
      if ($urandom_range(99) < row.gap_pct)
      begin
        in_valid = 1'b0;
        nonce    = $urandom;   // ignored while idle
      end
      else
      begin
        dig = keccak256_ref(hdr, n);
        m   = keccak_match_ref(dig, row.target, ZERO_BITS);
        exp_digest_q.push_back(dig);
        exp_match_q.push_back(m);
        exp_cycle_q.push_back(cycle_cnt + LATENCY);
        in_valid = 1'b1;
        header   = hdr;
        nonce    = n;
        target   = row.target;
        n++;
        sent++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_digest_q.size() != 0)
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timeout waiting for pipeline results");
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial
  begin
    void'($urandom(32'h570));
    rst_n    = 1'b0;
    in_valid = 1'b0;
    header   = '0;
    nonce    = '0;
    target   = '0;
    rows[0]   = '{32'h0000_0000, 32'h0000_0000, 1, 32'hffff_ffff, 0, -1};
    rows[1]   = '{32'h1a2b_3c4d, 32'h0000_1000, 512, 32'hffff_ffff, 0, -1};
    rows[2]   = '{32'h5e6f_7081, 32'h8000_0000, 256, 32'h0000_0000, 0, 0};
    rows[3]   = '{32'h9293_a4b5, 32'h0000_0040, 200, 32'h4000_0000, 40, -1};
    reset_row = '{32'hc0de_0001, 32'h0000_0000, 30, 32'hffff_ffff, 0, -1};
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // nothing may come out before the first input
    for (int i = 0; i < 2*LATENCY; i++)
    begin
      @(negedge clk);
      check_value("out_valid", out_valid, 1'b0);
    end

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      match_seen = 0;
      drive_row(rows[r]);
      wait_drain();
      if (rows[r].exp_matches >= 0)
        check_value("match_count", match_seen, rows[r].exp_matches);
    end

    // reset with a partly filled pipe
    drive_row(reset_row);
    rst_n = 1'b0;
    exp_digest_q.delete();
    exp_match_q.delete();
    exp_cycle_q.delete();
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
      check_value("out_valid", out_valid, 1'b0);
      check_value("match", match, 1'b0);
    end
    rst_n = 1'b1;
    for (int i = 0; i < 2*LATENCY; i++)
    begin
      @(negedge clk);
      check_value("out_valid", out_valid, 1'b0);  // no stale results
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* keccak_miner.sv */
`timescale 1ns/10ps
`default_nettype none

module keccak_miner
  import keccak_pkg::*;
#(
  parameter int ZERO_BITS = 224
)
(
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    in_valid,
  input  wire header_t header,
  input  wire nonce_t  nonce,
  input  wire target_t target,
  output digest_t      digest,
  output logic         match,
  output logic         out_valid
);

  block_t  pad_block;
  state_t  pipe_state;
  logic    pipe_valid;
  target_t pipe_target;

  keccak_block_pad u_pad (
    .header (header),
    .nonce  (nonce),
    .block  (pad_block)
  );

  keccak_round_pipe #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) u_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .block       (pad_block),
    .in_valid    (in_valid),
    .target      (target),
    .state_out   (pipe_state),
    .state_valid (pipe_valid),
    .target_out  (pipe_target)
  );

  keccak_target_check #(
    .ZERO_BITS (ZERO_BITS)
  ) u_check (
    .clk         (clk),
    .rst_n       (rst_n),
    .state_in    (pipe_state),
    .state_valid (pipe_valid),
    .target      (pipe_target),
    .digest      (digest),
    .match       (match),
    .out_valid   (out_valid)
  );

endmodule

`default_nettype wire

/* keccak_target_check.sv */
`timescale 1ns/10ps
`default_nettype none

module keccak_target_check
  import keccak_pkg::*;
#(
  parameter int ZERO_BITS = 224
)
(
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire state_t  state_in,
  input  wire logic    state_valid,
  input  wire target_t target,
  output digest_t      digest,
  output logic         match,
  output logic         out_valid
);

  digest_t digest_next;
  logic    zero_ok;
  logic    target_ok;
  logic    match_next;

  // lanes 0..3 byte swapped into big endian order
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      for (int j = 0; j < 8; j++)
      begin
        digest_next[DIGEST_W - 1 - 8*(8*k + j) -: 8] =
          state_in[STATE_W - LANE_W*(k+1) + 8*j +: 8];
      end
    end
  end

  assign zero_ok    = (digest_next >> (DIGEST_W - ZERO_BITS)) == '0;
  assign target_ok  = digest_next[TARGET_W-1:0] <= target;  // unsigned compare
  assign match_next = state_valid & zero_ok & target_ok;

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      match     <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      match     <= match_next;
      out_valid <= state_valid;
    end
  end

  always_ff @(posedge clk)
    digest <= digest_next;

endmodule

`default_nettype wire

/* keccak_round_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module keccak_round_pipe
  import keccak_pkg::*;
#(
  parameter int NUM_ROUNDS = keccak_pkg::NUM_ROUNDS
)
(
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire block_t  block,
  input  wire logic    in_valid,
  input  wire target_t target,
  output state_t       state_out,
  output logic         state_valid,
  output target_t      target_out
);

  // two registers per round, last round left open
  localparam int PIPE_DEPTH = 2*NUM_ROUNDS - 1;

  state_t                init_state;
  state_t                round_out [NUM_ROUNDS];
  state_t                stage_q [NUM_ROUNDS-1];
  logic [PIPE_DEPTH-1:0] valid_sr;
  target_t               target_sr [PIPE_DEPTH];

  assign init_state = {block, {(STATE_W - BLOCK_W){1'b0}}};  // capacity zeroed

  ////////////////////////////////////////
  // unrolled rounds
  ////////////////////////////////////////
  for (genvar r = 0; r < NUM_ROUNDS; r++)
  begin : g_round
    keccak_round u_round (
      .clk       (clk),
      .state_in  ((r == 0) ? init_state : stage_q[(r == 0) ? 0 : r-1]),
      .rc        (round_idx_t'(r)),
      .state_out (round_out[r])
    );

    if (r < NUM_ROUNDS-1)
    begin : g_stage
      always_ff @(posedge clk)
        stage_q[r] <= round_out[r];
    end
  end

  assign state_out = round_out[NUM_ROUNDS-1];

  // valid path, follows the state
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_sr <= '0;
    else
      valid_sr <= {valid_sr[PIPE_DEPTH-2:0], in_valid};
  end

  always_ff @(posedge clk)
  begin
    target_sr[0] <= target;
    for (int i = 1; i < PIPE_DEPTH; i++)
      target_sr[i] <= target_sr[i-1];
  end

  assign state_valid = valid_sr[PIPE_DEPTH-1];
  assign target_out  = target_sr[PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* keccak_round.sv */
`timescale 1ns/10ps
`default_nettype none

module keccak_round
  import keccak_pkg::*;
(
  input  wire logic       clk,
  input  wire state_t     state_in,
  input  wire round_idx_t rc,
  output state_t          state_out
);

  lane_t  a_lane [NUM_LANES];
  lane_t  parity [5];
  lane_t  theta_d [5];
  state_t theta_rho;
  state_t rho_q;      // mid-round register

  lane_t  pi_lane [NUM_LANES];
  lane_t  chi_lane [NUM_LANES];
  lane_t  rc_lane;

  function automatic lane_t rotl(lane_t v, int n);
    return (v << n) | (v >> (LANE_W - n));
  endfunction

  ////////////////////////////////////////
  // theta + rho, before the register
  ////////////////////////////////////////
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      a_lane[i] = state_in[STATE_W - 1 - LANE_W*i -: LANE_W];

    // column parities
    for (int x = 0; x < 5; x++)
      parity[x] = a_lane[x] ^ a_lane[x+5] ^ a_lane[x+10] ^ a_lane[x+15] ^ a_lane[x+20];

    for (int x = 0; x < 5; x++)
      theta_d[x] = parity[(x+4) % 5] ^ rotl(parity[(x+1) % 5], 1);

    for (int i = 0; i < NUM_LANES; i++)
    begin
      theta_rho[STATE_W - 1 - LANE_W*i -: LANE_W] =
        rotl(a_lane[i] ^ theta_d[i % 5], RHO_OFFSET[i]);
    end
  end

  always_ff @(posedge clk)
    rho_q <= theta_rho;

  ////////////////////////////////////////
  // pi, chi, iota after the register
  ////////////////////////////////////////
  always_comb
  begin
    // (x,y) moves to (y, 2x+3y)
    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        pi_lane[5*((2*x + 3*y) % 5) + y] =
          rho_q[STATE_W - 1 - LANE_W*(5*y + x) -: LANE_W];
      end
    end

    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        chi_lane[5*y + x] = pi_lane[5*y + x] ^
          (~pi_lane[5*y + (x+1) % 5] & pi_lane[5*y + (x+2) % 5]);
      end
    end

    // expand compact constant
    rc_lane = '0;
    for (int j = 0; j < 7; j++)
      rc_lane[(1 << j) - 1] = RC_TABLE[rc][j];

    for (int i = 0; i < NUM_LANES; i++)
      state_out[STATE_W - 1 - LANE_W*i -: LANE_W] = chi_lane[i];
    state_out[STATE_W - 1 -: LANE_W] = chi_lane[0] ^ rc_lane;  // iota on lane (0,0)
  end

endmodule

`default_nettype wire

/* keccak_block_pad.sv */
`timescale 1ns/10ps
`default_nettype none

module keccak_block_pad
  import keccak_pkg::*;
(
  input  wire header_t header,
  input  wire nonce_t  nonce,
  output block_t       block
);

  localparam int MSG_W  = HEADER_W + NONCE_W;     // 80 bytes
  localparam int FILL_W = BLOCK_W - MSG_W - 16;   // zeros between the pad bytes

  // message bytes in stream order, byte 0 at the top
  logic [BLOCK_W-1:0] msg;

  // original keccak padding, 0x01 ... 0x80
  assign msg = {header, nonce, 8'h01, {FILL_W{1'b0}}, 8'h80};

  // lanes are little endian: stream byte 8k+j goes to bits 8j+7:8j of lane k
  always_comb
  begin
    for (int k = 0; k < RATE_LANES; k++)
    begin
      for (int j = 0; j < 8; j++)
      begin
        block[BLOCK_W - LANE_W*(k+1) + 8*j +: 8] =
          msg[BLOCK_W - 1 - LANE_W*k - 8*j -: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* keccak_pkg.sv */
`default_nettype none

package keccak_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int NUM_ROUNDS = 24;
  localparam int LANE_W     = 64;
  localparam int NUM_LANES  = 25;
  localparam int RATE_LANES = 17;
  localparam int STATE_W    = NUM_LANES * LANE_W;   // 1600
  localparam int BLOCK_W    = RATE_LANES * LANE_W;  // 1088, rate part
  localparam int HEADER_W   = 608;
  localparam int NONCE_W    = 32;
  localparam int TARGET_W   = 32;
  localparam int DIGEST_W   = 256;

  typedef logic [LANE_W-1:0]   lane_t;
  typedef logic [STATE_W-1:0]  state_t;    // lane 5y+x counted from the msb end
  typedef logic [BLOCK_W-1:0]  block_t;
  typedef logic [HEADER_W-1:0] header_t;
  typedef logic [NONCE_W-1:0]  nonce_t;
  typedef logic [TARGET_W-1:0] target_t;
  typedef logic [DIGEST_W-1:0] digest_t;   // byte 0 in the top byte
  typedef logic [4:0]          round_idx_t;

  ////////////////////////////////////////
  // iota constants, compact form
  ////////////////////////////////////////
  // bit i lands on lane bit 2**i - 1
  localparam logic [6:0] RC_TABLE [NUM_ROUNDS] = '{
    7'b0000001, 7'b0011010, 7'b1011110, 7'b1110000,
    7'b0011111, 7'b0100001, 7'b1111001, 7'b1010101,
    7'b0001110, 7'b0001100, 7'b0110101, 7'b0100110,
    7'b0111111, 7'b1001111, 7'b1011101, 7'b1010011,
    7'b1010010, 7'b1001000, 7'b0010110, 7'b1100110,
    7'b1111001, 7'b1011000, 7'b0100001, 7'b1110100
  };

  ////////////////////////////////////////
  // rho rotations, left, per lane 5y+x
  ////////////////////////////////////////
  localparam int RHO_OFFSET [NUM_LANES] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

endpackage

`default_nettype wire
